// File: src/rnn_pkg.sv
package rnn_pkg;

    // Network sizes
    localparam int VOCAB_SIZE  = 76;
    localparam int EMBED_SIZE  = 4;
    localparam int HIDDEN_SIZE = 8;

    // Word and bus widths
    localparam int DATA_W  = 16;
    localparam int FRAC_W  = 8;                // Q8.8 fraction bits
    localparam int ADDR_W  = 27;
    localparam int TOKEN_W = 7;

    // Parameter memory map, one 16-bit word per address

    // Embedding table, token-major
    localparam int EMBED_BASE = 0;

    // Input-to-hidden weights, neuron j input e at base + j*EMBED_SIZE + e
    localparam int W_IH_BASE = EMBED_BASE + VOCAB_SIZE * EMBED_SIZE;

    // Hidden-to-hidden weights, neuron j input k at base + j*HIDDEN_SIZE + k
    localparam int W_HH_BASE = W_IH_BASE + HIDDEN_SIZE * EMBED_SIZE;

    localparam int B_IH_BASE = W_HH_BASE + HIDDEN_SIZE * HIDDEN_SIZE;
    localparam int B_HH_BASE = B_IH_BASE + HIDDEN_SIZE;

    localparam int MEM_WORDS = B_HH_BASE + HIDDEN_SIZE;   // 416 words

endpackage

// File: src/param_mem_arbiter.sv
module param_mem_arbiter
    import rnn_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              fetch_req,
    input  logic [ADDR_W-1:0] fetch_address,
    input  logic              engine_req,
    input  logic [ADDR_W-1:0] engine_address,
    output logic              fetch_grant_valid,
    output logic              engine_grant_valid,
    output logic [DATA_W-1:0] grant_data,
    output logic              mem_read,
    output logic [ADDR_W-1:0] mem_address,
    input  logic [DATA_W-1:0] mem_read_data,
    input  logic              mem_read_valid
);

    logic locked;          // Read outstanding
    logic owner_q;         // Owner of the outstanding read, 1 = engine
    logic owner_engine;
    logic gap;             // Idle cycle after each completed read

    // Fetch wins unless a read is already in flight
    assign owner_engine = locked ? owner_q : !fetch_req;

    assign mem_read    = !gap && (locked || fetch_req || engine_req);
    assign mem_address = owner_engine ? engine_address : fetch_address;

    assign fetch_grant_valid  = mem_read_valid && !owner_engine;
    assign engine_grant_valid = mem_read_valid && owner_engine;
    assign grant_data         = mem_read_data;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            locked  <= 1'b0;
            owner_q <= 1'b0;
            gap     <= 1'b0;
        end
        else
        begin
            gap <= mem_read_valid;
            if (mem_read_valid)
                locked <= 1'b0;
            else if (mem_read)
                locked <= 1'b1;
            if (mem_read && !locked)
                owner_q <= owner_engine;   // Capture owner as the read is issued
        end
    end

endmodule

// File: src/embedding_fetch.sv
module embedding_fetch
    import rnn_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic               execute,
    input  logic [TOKEN_W-1:0] token,
    input  logic               engine_busy,
    output logic               req,
    output logic [ADDR_W-1:0]  req_address,
    input  logic               grant_valid,
    input  logic [DATA_W-1:0]  grant_data,
    output logic               busy,
    output logic               embed_ready,
    output logic [DATA_W-1:0]  embedding [EMBED_SIZE]
);

    logic                          reading;
    logic                          accept;
    logic [TOKEN_W-1:0]            token_q;
    logic [$clog2(EMBED_SIZE)-1:0] word_idx;

    // Stay busy through the ready pulse so busy is continuous into the engine
    assign busy   = reading || embed_ready;
    assign accept = execute && !busy && !engine_busy;

    assign req         = reading;
    assign req_address = ADDR_W'(EMBED_BASE + int'(token_q) * EMBED_SIZE + int'(word_idx));

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            reading     <= 1'b0;
            embed_ready <= 1'b0;
            word_idx    <= '0;
        end
        else
        begin
            embed_ready <= 1'b0;
            if (accept)
            begin
                reading  <= 1'b1;
                word_idx <= '0;
            end
            else if (reading && grant_valid)
            begin
                word_idx <= word_idx + 1'b1;
                if (word_idx == EMBED_SIZE - 1)
                begin
                    reading     <= 1'b0;
                    embed_ready <= 1'b1;     // All words stored
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
            token_q <= token;
        if (reading && grant_valid)
            embedding[word_idx] <= grant_data;
    end

endmodule

// File: src/neuron_engine.sv
module neuron_engine
    import rnn_pkg::*;
(
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           embed_ready,
    input  logic [DATA_W-1:0]              embedding [EMBED_SIZE],
    output logic                           req,
    output logic [ADDR_W-1:0]              req_address,
    input  logic                           grant_valid,
    input  logic [DATA_W-1:0]              grant_data,
    output logic                           busy,
    output logic                           neuron_valid,
    output logic [$clog2(HIDDEN_SIZE)-1:0] neuron_index,
    output logic [DATA_W-1:0]              neuron_value,
    output logic                           done
);

    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_RUN  = 2'd1;
    localparam logic [1:0] S_COPY = 2'd2;

    localparam logic [1:0] PH_HH  = 2'd0;    // Hidden weights times old state
    localparam logic [1:0] PH_BHH = 2'd1;
    localparam logic [1:0] PH_IH  = 2'd2;    // Input weights times embedding
    localparam logic [1:0] PH_BIH = 2'd3;

    logic [1:0]                     state;
    logic [1:0]                     phase;
    logic [$clog2(HIDDEN_SIZE)-1:0] neuron;
    logic [$clog2(HIDDEN_SIZE)-1:0] k;
    logic [DATA_W-1:0]              old_h [HIDDEN_SIZE];
    logic [DATA_W-1:0]              new_h [HIDDEN_SIZE];
    logic [DATA_W-1:0]              acc;

    logic [DATA_W-1:0]              operand;
    logic signed [2*DATA_W-1:0]     product;
    logic [DATA_W-1:0]              term;
    logic [DATA_W-1:0]              acc_next;
    logic                           take;

    assign busy = (state != S_IDLE);
    assign req  = (state == S_RUN);
    assign take = req && grant_valid;

    always_comb
    begin
        case (phase)
            PH_HH:   req_address = ADDR_W'(W_HH_BASE + int'(neuron) * HIDDEN_SIZE + int'(k));
            PH_BHH:  req_address = ADDR_W'(B_HH_BASE + int'(neuron));
            PH_IH:   req_address = ADDR_W'(W_IH_BASE + int'(neuron) * EMBED_SIZE + int'(k));
            default: req_address = ADDR_W'(B_IH_BASE + int'(neuron));
        endcase
    end

    // Q8.8 multiply-accumulate, products truncated and sums wrapping
    always_comb
    begin
        operand = (phase == PH_HH) ? old_h[k] : embedding[k[$clog2(EMBED_SIZE)-1:0]];
        product = $signed(grant_data) * $signed(operand);
        if (phase == PH_HH || phase == PH_IH)
            term = product[FRAC_W +: DATA_W];
        else
            term = grant_data;                 // Bias words add directly
        acc_next = acc + term;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state        <= S_IDLE;
            phase        <= PH_HH;
            neuron       <= '0;
            k            <= '0;
            neuron_valid <= 1'b0;
            done         <= 1'b0;
            for (int i = 0; i < HIDDEN_SIZE; i++)
            begin
                old_h[i] <= '0;
                new_h[i] <= '0;
            end
        end
        else
        begin
            neuron_valid <= 1'b0;
            done         <= 1'b0;
            case (state)
                S_IDLE:
                begin
                    if (embed_ready)
                    begin
                        state  <= S_RUN;
                        phase  <= PH_HH;
                        neuron <= '0;
                        k      <= '0;
                    end
                end
                S_RUN:
                begin
                    if (grant_valid)
                    begin
                        case (phase)
                            PH_HH:
                            begin
                                if (k == HIDDEN_SIZE - 1)
                                begin
                                    phase <= PH_BHH;
                                    k     <= '0;
                                end
                                else
                                    k <= k + 1'b1;
                            end
                            PH_BHH:
                                phase <= PH_IH;
                            PH_IH:
                            begin
                                if (k == EMBED_SIZE - 1)
                                begin
                                    phase <= PH_BIH;
                                    k     <= '0;
                                end
                                else
                                    k <= k + 1'b1;
                            end
                            default:
                            begin
                                new_h[neuron] <= acc_next;
                                neuron_valid  <= 1'b1;
                                phase         <= PH_HH;
                                if (neuron == HIDDEN_SIZE - 1)
                                    state <= S_COPY;
                                else
                                    neuron <= neuron + 1'b1;
                            end
                        endcase
                    end
                end
                default:
                begin
                    old_h <= new_h;    // Next step sees this step's state
                    done  <= 1'b1;
                    state <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == S_IDLE)
            acc <= '0;
        else if (take)
            acc <= (phase == PH_BIH) ? '0 : acc_next;
        if (take && phase == PH_BIH)
        begin
            neuron_index <= neuron;
            neuron_value <= acc_next;
        end
    end

endmodule

// File: src/rnn_cell_top.sv
module rnn_cell_top
    import rnn_pkg::*;
(
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           execute,
    input  logic [TOKEN_W-1:0]             token,
    input  logic [DATA_W-1:0]              mem_read_data,
    input  logic                           mem_read_valid,
    output logic                           mem_read,
    output logic [ADDR_W-1:0]              mem_address,
    output logic                           busy,
    output logic                           neuron_valid,
    output logic [$clog2(HIDDEN_SIZE)-1:0] neuron_index,
    output logic [DATA_W-1:0]              neuron_value,
    output logic                           done
);

    logic              fetch_req;
    logic [ADDR_W-1:0] fetch_address;
    logic              fetch_grant_valid;
    logic              fetch_busy;
    logic              engine_req;
    logic [ADDR_W-1:0] engine_address;
    logic              engine_grant_valid;
    logic              engine_busy;
    logic [DATA_W-1:0] grant_data;
    logic              embed_ready;
    logic [DATA_W-1:0] embedding [EMBED_SIZE];

    assign busy = fetch_busy || engine_busy;

    embedding_fetch u_fetch (
        .clk         (clk),
        .reset       (reset),
        .execute     (execute),
        .token       (token),
        .engine_busy (engine_busy),
        .req         (fetch_req),
        .req_address (fetch_address),
        .grant_valid (fetch_grant_valid),
        .grant_data  (grant_data),
        .busy        (fetch_busy),
        .embed_ready (embed_ready),
        .embedding   (embedding)
    );

    neuron_engine u_engine (
        .clk          (clk),
        .reset        (reset),
        .embed_ready  (embed_ready),
        .embedding    (embedding),
        .req          (engine_req),
        .req_address  (engine_address),
        .grant_valid  (engine_grant_valid),
        .grant_data   (grant_data),
        .busy         (engine_busy),
        .neuron_valid (neuron_valid),
        .neuron_index (neuron_index),
        .neuron_value (neuron_value),
        .done         (done)
    );

    param_mem_arbiter u_arbiter (
        .clk                (clk),
        .reset              (reset),
        .fetch_req          (fetch_req),
        .fetch_address      (fetch_address),
        .engine_req         (engine_req),
        .engine_address     (engine_address),
        .fetch_grant_valid  (fetch_grant_valid),
        .engine_grant_valid (engine_grant_valid),
        .grant_data         (grant_data),
        .mem_read           (mem_read),
        .mem_address        (mem_address),
        .mem_read_data      (mem_read_data),
        .mem_read_valid     (mem_read_valid)
    );

endmodule

// File: sim/param_mem_model.sv
module param_mem_model
    import rnn_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic [2:0]        latency,
    input  logic              mem_read,
    input  logic [ADDR_W-1:0] mem_address,
    output logic [DATA_W-1:0] mem_read_data,
    output logic              mem_read_valid
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [DATA_W-1:0] mem [MEM_WORDS];    // Written by the testbench
    logic              pending;
    logic [2:0]        remaining;

    function automatic logic [DATA_W-1:0] read_word(input logic [ADDR_W-1:0] address);
        if (address < MEM_WORDS)
            return mem[int'(address)];
        return '0;                          // Outside the map reads as zero
    endfunction

    // Latency counts from the edge that first sees mem_read
    always @(posedge clk)
    begin
        if (reset)
        begin
            pending        <= 1'b0;
            remaining      <= '0;
            mem_read_valid <= 1'b0;
            mem_read_data  <= '0;
        end
        else
        begin
            mem_read_valid <= 1'b0;
            if (pending)
            begin
                remaining <= remaining - 1'b1;
                if (remaining == 3'd1)
                begin
                    pending        <= 1'b0;
                    mem_read_valid <= 1'b1;
                    mem_read_data  <= read_word(mem_address);
                end
            end
            else if (mem_read && !mem_read_valid)
            begin
                if (latency <= 3'd1)
                begin
                    mem_read_valid <= 1'b1;
                    mem_read_data  <= read_word(mem_address);
                end
                else
                begin
                    pending   <= 1'b1;
                    remaining <= latency - 1'b1;
                end
            end
        end
    end

endmodule

// File: sim/rnn_cell_assert.sv
module rnn_cell_assert
    import rnn_pkg::*;
(
    input logic              clk,
    input logic              reset,
    input logic              mem_read,
    input logic [ADDR_W-1:0] mem_address,
    input logic              mem_read_valid,
    input logic              busy,
    input logic              neuron_valid,
    input logic              done
);

    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;    // Read by the testbench summary

    // Back-pressure: request and address hold until the valid pulse
    address_stable: assert property (@(posedge clk) disable iff (reset)
        mem_read && !mem_read_valid |=> mem_read && $stable(mem_address))
    else
    begin
        $error("mem_read or mem_address changed before mem_read_valid arrived");
        fail_count++;
    end

    done_pulse: assert property (@(posedge clk) disable iff (reset) done |=> !done)
    else
    begin
        $error("done stayed high for more than one cycle");
        fail_count++;
    end

    strobe_pulse: assert property (@(posedge clk) disable iff (reset)
        neuron_valid |=> !neuron_valid)
    else
    begin
        $error("neuron_valid stayed high for more than one cycle");
        fail_count++;
    end

    idle_in_reset: assert property (@(posedge clk)
        reset |=> !busy && !mem_read && !neuron_valid && !done)
    else
    begin
        $error("control outputs not low after a reset cycle");
        fail_count++;
    end

endmodule

bind rnn_cell_top rnn_cell_assert u_assert (
    .clk            (clk),
    .reset          (reset),
    .mem_read       (mem_read),
    .mem_address    (mem_address),
    .mem_read_valid (mem_read_valid),
    .busy           (busy),
    .neuron_valid   (neuron_valid),
    .done           (done)
);

// File: sim/rnn_cell_tb.sv
module rnn_cell_tb
    import rnn_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] SEED         = 32'hb7c8_224e;
    localparam int          STEP_TIMEOUT = 3000;
    localparam int          QUIET_CYCLES = 40;

    logic              clk = 1'b0;
    logic              reset;
    logic              execute;
    logic [TOKEN_W-1:0] token;
    logic [DATA_W-1:0] mem_read_data;
    logic              mem_read_valid;
    logic              mem_read;
    logic [ADDR_W-1:0] mem_address;
    logic              busy;
    logic              neuron_valid;
    logic [2:0]        neuron_index;
    logic [DATA_W-1:0] neuron_value;
    logic              done;
    logic [2:0]        mem_latency;

    logic [31:0]       rng_state;
    logic [DATA_W-1:0] mem_image [MEM_WORDS];
    logic [DATA_W-1:0] ref_h [HIDDEN_SIZE];       // Old state of the reference model
    logic [DATA_W-1:0] expected_h [HIDDEN_SIZE];
    logic [DATA_W-1:0] observed_h [HIDDEN_SIZE];
    logic [DATA_W-1:0] first_h [HIDDEN_SIZE];
    int                errors;
    int                checks;
    int                tests_run;
    int                tests_failed;
    int                mark;

    rnn_cell_top dut (.*);

    param_mem_model mem_model (
        .clk            (clk),
        .reset          (reset),
        .latency        (mem_latency),
        .mem_read       (mem_read),
        .mem_address    (mem_address),
        .mem_read_data  (mem_read_data),
        .mem_read_valid (mem_read_valid)
    );

    always #5 clk = ~clk;

    always @(posedge clk)
    begin
        #1;
        rng_state   = xorshift(rng_state);
        mem_latency = 3'd1 + {1'b0, rng_state[1:0]};    // 1 to 4 cycles
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Q8.8 product, full signed product shifted right by the fraction width
    function automatic logic [DATA_W-1:0] q_mul(input logic [DATA_W-1:0] a, b);
        logic signed [2*DATA_W-1:0] full;
        full = $signed(a) * $signed(b);
        return DATA_W'(full >>> FRAC_W);
    endfunction

    function automatic void compute_step(input int tok);
        logic [DATA_W-1:0] emb [EMBED_SIZE];
        logic [DATA_W-1:0] acc;
        for (int e = 0; e < EMBED_SIZE; e++)
            emb[e] = mem_image[EMBED_BASE + tok * EMBED_SIZE + e];
        for (int j = 0; j < HIDDEN_SIZE; j++)
        begin
            acc = '0;
            for (int k = 0; k < HIDDEN_SIZE; k++)
                acc = acc + q_mul(mem_image[W_HH_BASE + j * HIDDEN_SIZE + k], ref_h[k]);
            acc = acc + mem_image[B_HH_BASE + j];
            for (int e = 0; e < EMBED_SIZE; e++)
                acc = acc + q_mul(mem_image[W_IH_BASE + j * EMBED_SIZE + e], emb[e]);
            expected_h[j] = acc + mem_image[B_IH_BASE + j];
        end
    endfunction

    function automatic int error_total();
        return errors + dut.u_assert.fail_count;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got, exp);
        checks++;
        assert (got === exp)
        else
        begin
            $display("CHECK FAILED t=%0t %s got %0h expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic apply_reset();
        reset   = 1'b1;
        execute = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int i = 0; i < HIDDEN_SIZE; i++)
            ref_h[i] = '0;
    endtask

    task automatic check_idle(input int n);
        for (int i = 0; i < n; i++)
        begin
            @(negedge clk);
            check_value("busy", busy, 0);
            check_value("mem_read", mem_read, 0);
            check_value("neuron_valid", neuron_valid, 0);
            check_value("done", done, 0);
            @(posedge clk);
            #1;
        end
    endtask

    // One recurrent step, with an optional extra execute pulse while busy
    task automatic run_step(input int tok, input int stray_at);
        int  strobes;
        int  cycles;
        bit  finished;
        compute_step(tok);
        strobes  = 0;
        cycles   = 0;
        finished = 1'b0;
        token    = TOKEN_W'(tok);
        execute  = 1'b1;
        @(posedge clk);
        #1;
        execute = 1'b0;
        while (!finished && cycles < STEP_TIMEOUT)
        begin
            @(negedge clk);
            cycles++;
            if (neuron_valid && strobes < HIDDEN_SIZE)
            begin
                check_value("neuron_index", neuron_index, strobes);
                check_value("neuron_value", neuron_value, expected_h[strobes]);
                observed_h[strobes] = neuron_value;
                strobes++;
            end
            else if (neuron_valid)
            begin
                $display("more than %0d neuron strobes for token %0d", HIDDEN_SIZE, tok);
                errors++;
            end
            if (done)
            begin
                check_value("strobe_count", strobes, HIDDEN_SIZE);
                check_value("busy", busy, 0);
                finished = 1'b1;
            end
            @(posedge clk);
            #1;
            execute = (cycles == stray_at);
        end
        execute = 1'b0;
        if (!finished)
        begin
            $display("timeout: no done within %0d cycles for token %0d", STEP_TIMEOUT, tok);
            errors++;
        end
        ref_h = expected_h;
        check_idle(QUIET_CYCLES);    // No second step, no late strobe
    endtask

    task automatic finish_test(input string name);
        int now_errors;
        now_errors = error_total();
        tests_run++;
        if (now_errors != mark)
        begin
            tests_failed++;
            $display("test %0d %s: fail, %0d errors", tests_run, name, now_errors - mark);
        end
        else
        begin
            $display("test %0d %s: ok", tests_run, name);
        end
        mark = now_errors;
    endtask

    initial
    begin
        reset        = 1'b1;
        execute      = 1'b0;
        token        = '0;
        mem_latency  = 3'd1;
        rng_state    = SEED;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        mark         = 0;
        for (int i = 0; i < MEM_WORDS; i++)
        begin
            rng_state        = xorshift(rng_state);
            mem_image[i]     = DATA_W'($signed(rng_state[8:0]));    // Within +-1.0
            mem_model.mem[i] = mem_image[i];
        end
        apply_reset();

        check_idle(20);
        finish_test("reset_idle");

        run_step(17, 0);
        first_h = expected_h;
        finish_test("first_step");

        run_step(42, 0);
        finish_test("recurrence");

        run_step(0, 0);
        run_step(VOCAB_SIZE - 1, 0);
        finish_test("table_edges");

        run_step(9, 15);
        finish_test("execute_busy");

        apply_reset();
        run_step(17, 0);
        for (int j = 0; j < HIDDEN_SIZE; j++)
            check_value("neuron_value", observed_h[j], first_h[j]);
        finish_test("reset_repeat");

        $display("tests run %0d, tests failing %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, error_total());
        if (error_total() == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

// File: build.f
src/rnn_pkg.sv
src/param_mem_arbiter.sv
src/embedding_fetch.sv
src/neuron_engine.sv
src/rnn_cell_top.sv
sim/param_mem_model.sv
sim/rnn_cell_assert.sv
sim/rnn_cell_tb.sv
